// File: hdl/apb_regs.sv
`default_nettype none
`timescale 1ns/10ps

module apb_regs import play_pkg::*; #(
    parameter int CHART_LEN = 64
) (
    input  logic               prog_clk,
    input  logic               rst,
    input  logic [11:0]        paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    chart_if.loader            chart,
    output logic               start,
    output logic               auto_play,
    output logic [$clog2(CHART_LEN+1)-1:0] note_cnt,
    input  play_state_t        state,
    input  logic [1:0]         cnt_dn,
    input  logic               saved,
    input  logic [$clog2(CHART_LEN+1)-1:0] index,
    input  logic [SCORE_W-1:0] score,
    input  logic [SCORE_W-1:0] saved_score
);

    localparam int IW = $clog2(CHART_LEN + 1);
    localparam int AW = $clog2(CHART_LEN);

    localparam logic [11:0] ADDR_CTRL     = 12'h000;
    localparam logic [11:0] ADDR_NOTE_CNT = 12'h004;
    localparam logic [11:0] ADDR_STATUS   = 12'h008;
    localparam logic [11:0] ADDR_SCORE    = 12'h00C;
    localparam logic [11:0] ADDR_SAVED    = 12'h010;
    localparam logic [11:0] SLOT_BASE     = 12'h100;

    logic        wr_access;
    logic        ctrl_wr;
    logic        slot_hit;
    logic [11:0] slot_off;

    // Zero wait states
    assign pready = 1'b1;

    assign wr_access = psel && penable && pwrite;
    assign ctrl_wr   = wr_access && (paddr == ADDR_CTRL);
    assign start     = ctrl_wr && pwdata[0];

    // Chart slots sit at 0x100 + 4*i
    assign slot_off = paddr - SLOT_BASE;
    assign slot_hit = (paddr >= SLOT_BASE) && (slot_off[11:2] < CHART_LEN);

    assign chart.wr_en   = wr_access && slot_hit;
    assign chart.wr_idx  = slot_off[2 +: AW];
    assign chart.wr_note = pwdata[8:0];

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            note_cnt  <= '0;
            auto_play <= 1'b0;
        end else begin
            if (wr_access && (paddr == ADDR_NOTE_CNT)) begin
                note_cnt <= pwdata[IW-1:0];
            end
            // Mode is only taken when a run can actually start
            if (ctrl_wr && (state == ST_MENU)) begin
                auto_play <= pwdata[1];
            end
        end
    end

    // Read mux, STATUS is {index at bit 8, saved, digit, state}
    always_comb begin
        prdata = '0;
        case (paddr)
            ADDR_NOTE_CNT: prdata[IW-1:0] = note_cnt;
            ADDR_STATUS: begin
                prdata[1:0]      = state;
                prdata[3:2]      = cnt_dn;
                prdata[4]        = saved;
                prdata[8 +: IW]  = index;
            end
            ADDR_SCORE:    prdata[SCORE_W-1:0] = score;
            ADDR_SAVED:    prdata[SCORE_W-1:0] = saved_score;
            default:       prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/chart_if.sv
`default_nettype none
`timescale 1ns/10ps

interface chart_if import play_pkg::*; #(
    parameter int CHART_LEN = 64
) ();
    localparam int IDX_W = $clog2(CHART_LEN);

    // Write side, loaded over APB
    logic             wr_en;
    logic [IDX_W-1:0] wr_idx;
    note_t            wr_note;

    // Read side, addressed by the note index
    logic [IDX_W-1:0] rd_idx;
    note_t            rd_note;

    modport loader (output wr_en, wr_idx, wr_note);
    modport reader (output rd_idx, input rd_note);
    modport mem (input wr_en, wr_idx, wr_note, rd_idx, output rd_note);

endinterface

`default_nettype wire

// File: hdl/chart_mem.sv
`default_nettype none
`timescale 1ns/10ps

module chart_mem import play_pkg::*; #(
    parameter int CHART_LEN = 64
) (
    input logic    prog_clk,
    chart_if.mem   chart
);

    note_t slots [CHART_LEN];

    // Slot write from the register block
    always_ff @(posedge prog_clk) begin
        if (chart.wr_en) begin
            slots[chart.wr_idx] <= chart.wr_note;
        end
    end

    // Current note is looked up without a clock
    assign chart.rd_note = slots[chart.rd_idx];

endmodule

`default_nettype wire

// File: hdl/note_decode.sv
`default_nettype none
`timescale 1ns/10ps

module note_decode import play_pkg::*; (
    input  logic       prog_clk,
    input  logic       rst,
    input  logic       playing,
    input  note_t      note,
    output logic [7:0] led,
    output byte        seg_letter,
    output byte        seg_oct,
    output byte        seg_digit
);

    logic [2:0] key_pos;
    logic       valid;
    logic [7:0] led_nx;
    byte        letter_nx;
    byte        oct_nx;
    byte        digit_nx;

    // Position of the lit key
    always_comb begin
        key_pos = '0;
        for (int i = 0; i < 7; i++) begin
            if (note.keys[i]) key_pos = 3'(i);
        end
    end

    // One key, and never both octave flags
    assign valid = $onehot(note.keys) && !(note.oct_up && note.oct_down);

    always_comb begin
        led_nx    = 8'h00;
        letter_nx = " ";
        oct_nx    = " ";
        digit_nx  = " ";
        if (valid) begin
            // C on the leftmost LED, bit 0 shows an octave shift
            led_nx    = 8'h80 >> key_pos;
            led_nx[0] = note.oct_up | note.oct_down;
            digit_nx  = "1" + {5'd0, key_pos};
            case (key_pos)
                3'd0:    letter_nx = "c";
                3'd1:    letter_nx = "d";
                3'd2:    letter_nx = "e";
                3'd3:    letter_nx = "f";
                3'd4:    letter_nx = "g";
                3'd5:    letter_nx = "a";
                default: letter_nx = "b";
            endcase
            if (note.oct_up) begin
                oct_nx = "u";
            end else if (note.oct_down) begin
                oct_nx = "d";
            end
        end
    end

    // Display holds outside play
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            led        <= 8'h00;
            seg_letter <= " ";
            seg_oct    <= " ";
            seg_digit  <= " ";
        end else if (playing) begin
            led        <= led_nx;
            seg_letter <= letter_nx;
            seg_oct    <= oct_nx;
            seg_digit  <= digit_nx;
        end
    end

endmodule

`default_nettype wire

// File: hdl/play_chart_top.sv
`default_nettype none
`timescale 1ns/10ps

module play_chart_top import play_pkg::*; #(
    parameter int CHART_LEN   = 64,
    parameter int STEP_CYCLES = 16,
    parameter int CD_STEPS    = 10
) (
    input  logic        prog_clk,
    input  logic        rst,
    input  logic [11:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    input  logic [6:0]  note_keys,
    input  logic        oct_up,
    input  logic        oct_down,
    input  arrow_t      arrow,
    output logic [7:0]  led,
    output byte         seg_letter,
    output byte         seg_oct,
    output byte         seg_digit
);

    localparam int IW = $clog2(CHART_LEN + 1);

    logic               start;
    logic               auto_play;
    logic [IW-1:0]      note_cnt;
    logic [IW-1:0]      index;
    logic               step;
    logic               clear;
    logic               playing;
    logic               saved;
    logic [1:0]         cnt_dn;
    logic [SCORE_W-1:0] score;
    logic [SCORE_W-1:0] saved_score;
    play_state_t        state;

    chart_if #(.CHART_LEN(CHART_LEN)) chart_bus ();

    apb_regs #(.CHART_LEN(CHART_LEN)) u_regs (
        .prog_clk(prog_clk), .rst(rst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .chart(chart_bus.loader),
        .start(start), .auto_play(auto_play), .note_cnt(note_cnt),
        .state(state), .cnt_dn(cnt_dn), .saved(saved), .index(index),
        .score(score), .saved_score(saved_score)
    );

    chart_mem #(.CHART_LEN(CHART_LEN)) u_mem (
        .prog_clk(prog_clk),
        .chart(chart_bus.mem)
    );

    play_ctrl #(
        .CHART_LEN(CHART_LEN),
        .STEP_CYCLES(STEP_CYCLES),
        .CD_STEPS(CD_STEPS)
    ) u_ctrl (
        .prog_clk(prog_clk), .rst(rst),
        .start(start), .note_cnt(note_cnt), .arrow(arrow),
        .chart(chart_bus.reader),
        .step(step), .clear(clear), .playing(playing),
        .state(state), .cnt_dn(cnt_dn), .index(index), .saved(saved),
        .score(score), .saved_score(saved_score)
    );

    // Judge and display both see the note at the current index
    score_judge u_judge (
        .prog_clk(prog_clk), .rst(rst),
        .clear(clear), .step(step), .playing(playing), .auto_play(auto_play),
        .chart_note(chart_bus.rd_note),
        .note_keys(note_keys), .oct_up(oct_up), .oct_down(oct_down),
        .score(score)
    );

    note_decode u_decode (
        .prog_clk(prog_clk), .rst(rst),
        .playing(playing), .note(chart_bus.rd_note),
        .led(led), .seg_letter(seg_letter), .seg_oct(seg_oct), .seg_digit(seg_digit)
    );

endmodule

`default_nettype wire

// File: hdl/play_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

module play_ctrl import play_pkg::*; #(
    parameter int CHART_LEN   = 64,
    parameter int STEP_CYCLES = 16,
    parameter int CD_STEPS    = 10
) (
    input  logic               prog_clk,
    input  logic               rst,
    input  logic               start,
    input  logic [$clog2(CHART_LEN+1)-1:0] note_cnt,
    input  arrow_t             arrow,
    chart_if.reader            chart,
    output logic               step,
    output logic               clear,
    output logic               playing,
    output play_state_t        state,
    output logic [1:0]         cnt_dn,
    output logic [$clog2(CHART_LEN+1)-1:0] index,
    output logic               saved,
    input  logic [SCORE_W-1:0] score,
    output logic [SCORE_W-1:0] saved_score
);

    localparam int AW = $clog2(CHART_LEN);
    localparam int TW = $clog2(STEP_CYCLES + 1);
    localparam int CW = $clog2(CD_STEPS + 1);

    logic [TW-1:0] step_tmr;
    logic [CW-1:0] cd_cnt;
    logic          running;

    assign running = (state == ST_COUNT) || (state == ST_PLAY);
    assign step    = running && (step_tmr == TW'(STEP_CYCLES - 1));
    assign clear   = start && (state == ST_MENU);
    // Index equal to note_cnt means the chart is exhausted
    assign playing = (state == ST_PLAY) && (index != note_cnt);

    assign chart.rd_idx = index[AW-1:0];

    // Step timer, held at zero outside a run
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            step_tmr <= '0;
        end else if (!running || step) begin
            step_tmr <= '0;
        end else begin
            step_tmr <= step_tmr + 1'b1;
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            state       <= ST_MENU;
            cnt_dn      <= 2'd3;
            cd_cnt      <= '0;
            index       <= '0;
            saved       <= 1'b0;
            saved_score <= '0;
        end else begin
            case (state)
                ST_MENU: begin
                    if (start) begin
                        state  <= ST_COUNT;
                        cnt_dn <= 2'd3;
                        cd_cnt <= '0;
                        index  <= '0;
                    end
                end
                ST_COUNT: begin
                    if (arrow == ARROW_LEFT) begin
                        state <= ST_MENU;
                    end else if (step) begin
                        if (cd_cnt == CW'(CD_STEPS - 1)) begin
                            cd_cnt <= '0;
                            // Digit 0 done, play begins
                            if (cnt_dn == 2'd0) begin
                                state <= ST_PLAY;
                                index <= '0;
                            end else begin
                                cnt_dn <= cnt_dn - 1'b1;
                            end
                        end else begin
                            cd_cnt <= cd_cnt + 1'b1;
                        end
                    end
                end
                ST_PLAY: begin
                    if (arrow == ARROW_LEFT) begin
                        state <= ST_MENU;
                    end else if (index == note_cnt) begin
                        state <= ST_DONE;
                    end else if (step) begin
                        index <= index + 1'b1;
                    end
                end
                ST_DONE: begin
                    if (arrow == ARROW_LEFT) begin
                        state <= ST_MENU;
                    end else if (arrow == ARROW_RIGHT) begin
                        // Keep this run as the record
                        saved_score <= score;
                        saved       <= 1'b1;
                        state       <= ST_MENU;
                    end
                end
                default: state <= ST_MENU;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/play_pkg.sv
`default_nettype none

package play_pkg;

    // One chart note or one sampled key set
    typedef struct packed {
        logic       oct_down;
        logic       oct_up;
        logic [6:0] keys;     // One-hot, C in bit 0
    } note_t;

    // Run state of the play screen
    typedef enum logic [1:0] {
        ST_MENU  = 2'd0,
        ST_COUNT = 2'd1,
        ST_PLAY  = 2'd2,
        ST_DONE  = 2'd3
    } play_state_t;

    // Arrow keys from the keypad
    typedef enum logic [1:0] {
        ARROW_NONE  = 2'd0,
        ARROW_LEFT  = 2'd1,
        ARROW_RIGHT = 2'd2
    } arrow_t;

    // Score counter width, wraps on overflow
    localparam int SCORE_W = 14;

    // Points per step
    localparam logic [SCORE_W-1:0] PTS_HIT   = SCORE_W'(4);
    localparam logic [SCORE_W-1:0] PTS_LATE2 = SCORE_W'(2);
    localparam logic [SCORE_W-1:0] PTS_LATE3 = SCORE_W'(1);

endpackage

`default_nettype wire

// File: hdl/score_judge.sv
`default_nettype none
`timescale 1ns/10ps

module score_judge import play_pkg::*; (
    input  logic               prog_clk,
    input  logic               rst,
    input  logic               clear,
    input  logic               step,
    input  logic               playing,
    input  logic               auto_play,
    input  note_t              chart_note,
    input  logic [6:0]         note_keys,
    input  logic               oct_up,
    input  logic               oct_down,
    output logic [SCORE_W-1:0] score
);

    note_t              sample;
    note_t              hist1;
    note_t              hist2;
    note_t              hist3;
    logic [SCORE_W-1:0] pts;

    assign sample = {oct_down, oct_up, note_keys};

    // Full credit for on time or one step late
    always_comb begin
        if (auto_play) begin
            pts = PTS_HIT;
        end else if ((chart_note == sample) || (chart_note == hist1)) begin
            pts = PTS_HIT;
        end else if (chart_note == hist2) begin
            pts = PTS_LATE2;
        end else if (chart_note == hist3) begin
            pts = PTS_LATE3;
        end else begin
            pts = '0;
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            score <= '0;
            hist1 <= '0;
            hist2 <= '0;
            hist3 <= '0;
        end else if (clear) begin
            score <= '0;
            hist1 <= '0;
            hist2 <= '0;
            hist3 <= '0;
        end else if (step && playing) begin
            score <= score + pts;
            hist3 <= hist2;
            hist2 <= hist1;
            hist1 <= sample;
        end
    end

endmodule

`default_nettype wire

// File: project.f
hdl/play_pkg.sv
hdl/chart_if.sv
hdl/chart_mem.sv
hdl/apb_regs.sv
hdl/play_ctrl.sv
hdl/score_judge.sv
hdl/note_decode.sv
hdl/play_chart_top.sv
tests/tb_play_chart.sv

// File: tests/tb_play_chart.sv
`timescale 1ns/10ps
`default_nettype none

module tb_play_chart import play_pkg::*;;

    localparam int CHART_LEN    = 16;
    localparam int STEP_CYCLES  = 4;
    localparam int CD_STEPS     = 2;
    localparam int CLK_PERIOD   = 8;
    localparam int NUM_RUNS     = 7;
    localparam int DIGIT_CYCLES = CD_STEPS * STEP_CYCLES;
    localparam int COUNT_CYCLES = 4 * DIGIT_CYCLES;
    localparam int RUN_CYCLES   = (4 * CD_STEPS + CHART_LEN + 10) * STEP_CYCLES;
    // Chart loading and register traffic around each run
    localparam int LOAD_CYCLES  = 3 * (CHART_LEN + 10);
    localparam int LIMIT_CYCLES = NUM_RUNS * (RUN_CYCLES + LOAD_CYCLES) + 200;

    localparam logic [11:0] ADDR_CTRL     = 12'h000;
    localparam logic [11:0] ADDR_NOTE_CNT = 12'h004;
    localparam logic [11:0] ADDR_STATUS   = 12'h008;
    localparam logic [11:0] ADDR_SCORE    = 12'h00C;
    localparam logic [11:0] ADDR_SAVED    = 12'h010;
    localparam logic [11:0] SLOT_BASE     = 12'h100;

    logic        prog_clk;
    logic        rst;
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic [6:0]  note_keys;
    logic        oct_up;
    logic        oct_down;
    arrow_t      arrow;
    logic [7:0]  led;
    byte         seg_letter;
    byte         seg_oct;
    byte         seg_digit;

    int                 errors;
    int                 checks;
    bit                 saved_flag;
    logic [SCORE_W-1:0] saved_model;
    note_t              chart_model [CHART_LEN];
    note_t              key_plan [CHART_LEN];

    play_chart_top #(
        .CHART_LEN(CHART_LEN),
        .STEP_CYCLES(STEP_CYCLES),
        .CD_STEPS(CD_STEPS)
    ) u_dut (
        .prog_clk(prog_clk), .rst(rst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .note_keys(note_keys), .oct_up(oct_up), .oct_down(oct_down), .arrow(arrow),
        .led(led), .seg_letter(seg_letter), .seg_oct(seg_oct), .seg_digit(seg_digit)
    );

    initial begin
        prog_clk = 1'b0;
        forever #(CLK_PERIOD / 2) prog_clk = ~prog_clk;
    end

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Error: %s expected 0x%08h actual 0x%08h", name, exp, act);
        end
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        @(posedge prog_clk);
        paddr   <= addr;
        pwdata  <= data;
        pwrite  <= 1'b1;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge prog_clk);
        penable <= 1'b1;
        // Write lands on this edge
        @(posedge prog_clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
        @(posedge prog_clk);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge prog_clk);
        penable <= 1'b1;
        @(negedge prog_clk);
        data = prdata;
        check_val("pready in access phase", 32'd1, {31'd0, pready});
        @(posedge prog_clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // Mostly valid notes with a raw 9-bit pattern now and then
    function automatic note_t rand_note();
        note_t nt;
        nt = '0;
        if ($urandom % 8 == 0) begin
            nt = 9'($urandom);
        end else begin
            nt.keys = 7'd1 << ($urandom % 7);
            case ($urandom % 3)
                1: nt.oct_up = 1'b1;
                2: nt.oct_down = 1'b1;
                default: nt.oct_up = 1'b0;
            endcase
        end
        return nt;
    endfunction

    // Player keys lean toward the note and the next few notes
    function automatic note_t pick_sample(input int j, input int n);
        int unsigned r;
        r = $urandom % 8;
        if (r < 3) return chart_model[j];
        if (r < 6 && j + r - 2 < n) return chart_model[j + r - 2];
        if (r == 6) return rand_note();
        if (r == 7 && j > 0) return chart_model[j - 1];
        return '0;
    endfunction

    function automatic int step_points(input note_t want, input note_t now, input note_t back1,
                                       input note_t back2, input note_t back3);
        if (want == now || want == back1) return 4;
        if (want == back2) return 2;
        if (want == back3) return 1;
        return 0;
    endfunction

    // LED and character model packed as {led, letter, octave, digit}
    function automatic logic [31:0] expect_display(input note_t nt);
        logic [55:0] letters;
        logic [7:0]  led_e;
        logic [7:0]  letter_e;
        logic [7:0]  oct_e;
        logic [7:0]  digit_e;
        int          pos;
        letters  = "cdefgab";
        led_e    = 8'h00;
        letter_e = " ";
        oct_e    = " ";
        digit_e  = " ";
        if ($countones(nt.keys) == 1 && !(nt.oct_up && nt.oct_down)) begin
            pos = 0;
            while (!nt.keys[pos]) pos++;
            led_e[7 - pos] = 1'b1;
            led_e[0]       = led_e[0] | nt.oct_up | nt.oct_down;
            letter_e       = letters[8 * (6 - pos) +: 8];
            digit_e        = 8'(49 + pos);
            if (nt.oct_up) oct_e = "u";
            if (nt.oct_down) oct_e = "d";
        end
        return {led_e, letter_e, oct_e, digit_e};
    endfunction

    function automatic logic [31:0] status_word(input logic [1:0] st, input int dg,
                                                input bit sv, input int ix);
        return (32'(ix) << 8) | (32'(sv) << 4) | (32'(dg) << 2) | {30'd0, st};
    endfunction

    task automatic check_reset();
        logic [31:0] rd;
        logic [31:0] cnt;
        @(negedge prog_clk);
        check_val("display after reset", 32'h0020_2020, {led, seg_letter, seg_oct, seg_digit});
        apb_read(ADDR_CTRL, rd);
        check_val("CTRL after reset", 32'd0, rd);
        apb_read(ADDR_NOTE_CNT, rd);
        check_val("NOTE_CNT after reset", 32'd0, rd);
        apb_read(ADDR_STATUS, rd);
        check_val("STATUS after reset", status_word(ST_MENU, 3, 1'b0, 0), rd);
        apb_read(ADDR_SCORE, rd);
        check_val("SCORE after reset", 32'd0, rd);
        apb_read(ADDR_SAVED, rd);
        check_val("SAVED_SCORE after reset", 32'd0, rd);
        apb_read(12'h020, rd);
        check_val("unmapped read", 32'd0, rd);
        // Nonzero so the readback differs from the reset value
        cnt = 1 + $urandom % CHART_LEN;
        apb_write(ADDR_NOTE_CNT, cnt);
        apb_read(ADDR_NOTE_CNT, rd);
        check_val("NOTE_CNT readback", cnt, rd);
    endtask

    task automatic play_run(input int run_no, input bit auto_mode, input int n, input int quit_k);
        note_t              hist1;
        note_t              hist2;
        note_t              hist3;
        logic [SCORE_W-1:0] exp_score;
        logic [1:0]         exp_st;
        logic [31:0]        rd;
        int                 k;
        int                 j;
        int                 exp_dg;
        int                 exp_ix;
        int                 off;
        int                 end_k;
        for (j = 0; j < n; j++) begin
            chart_model[j] = rand_note();
            apb_write(SLOT_BASE + 12'(4 * j), {23'd0, chart_model[j]});
        end
        for (j = 0; j < n; j++) begin
            key_plan[j] = pick_sample(j, n);
        end
        apb_write(ADDR_NOTE_CNT, 32'(n));
        apb_write(ADDR_CTRL, {30'd0, auto_mode, 1'b1});
        // Back-to-back STATUS polls with odd runs shifted by one cycle
        off     = run_no % 2;
        psel    <= (off == 0);
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= ADDR_STATUS;
        hist1     = '0;
        hist2     = '0;
        hist3     = '0;
        exp_score = '0;
        end_k     = COUNT_CYCLES + n * STEP_CYCLES + 2;
        for (k = 1; k <= end_k; k++) begin
            @(posedge prog_clk);
            if (k == quit_k) begin
                arrow   <= ARROW_LEFT;
                psel    <= 1'b0;
                penable <= 1'b0;
                break;
            end
            psel    <= 1'b1;
            penable <= ((k + off) % 2 == 1);
            if (k >= COUNT_CYCLES && (k - COUNT_CYCLES) % STEP_CYCLES == 0) begin
                j = (k - COUNT_CYCLES) / STEP_CYCLES;
                // This edge scored note j-1
                if (j > 0 && j <= n && !auto_mode) begin
                    exp_score = exp_score + SCORE_W'(step_points(chart_model[j - 1],
                                key_plan[j - 1], hist1, hist2, hist3));
                    hist3 = hist2;
                    hist2 = hist1;
                    hist1 = key_plan[j - 1];
                end
                if (j < n) begin
                    note_keys <= key_plan[j].keys;
                    oct_up    <= key_plan[j].oct_up;
                    oct_down  <= key_plan[j].oct_down;
                end
            end
            @(negedge prog_clk);
            if (penable) begin
                if (k < COUNT_CYCLES) begin
                    exp_st = ST_COUNT;
                    exp_dg = 3 - k / DIGIT_CYCLES;
                    exp_ix = 0;
                end else begin
                    exp_dg = 0;
                    exp_ix = (k - COUNT_CYCLES) / STEP_CYCLES;
                    if (exp_ix > n) exp_ix = n;
                    exp_st = (k <= COUNT_CYCLES + n * STEP_CYCLES) ? ST_PLAY : ST_DONE;
                end
                check_val($sformatf("run %0d STATUS at cycle %0d", run_no, k),
                          status_word(exp_st, exp_dg, saved_flag, exp_ix), prdata);
            end
            if (k > COUNT_CYCLES && (k - COUNT_CYCLES - 1) % STEP_CYCLES == 0) begin
                j = (k - COUNT_CYCLES - 1) / STEP_CYCLES;
                if (j < n) begin
                    check_val($sformatf("run %0d display of note %0d", run_no, j),
                              expect_display(chart_model[j]),
                              {led, seg_letter, seg_oct, seg_digit});
                end
            end
        end
        if (quit_k > 0 && quit_k <= end_k) begin
            @(posedge prog_clk);
            arrow <= ARROW_NONE;
            apb_read(ADDR_STATUS, rd);
            check_val($sformatf("run %0d state after left", run_no), ST_MENU, rd[1:0]);
            check_val($sformatf("run %0d saved flag after left", run_no), saved_flag, rd[4]);
            apb_read(ADDR_SAVED, rd);
            check_val($sformatf("run %0d SAVED_SCORE after left", run_no), saved_model, rd);
        end else begin
            @(posedge prog_clk);
            psel    <= 1'b0;
            penable <= 1'b0;
            if (auto_mode) exp_score = SCORE_W'(4 * n);
            apb_read(ADDR_SCORE, rd);
            check_val($sformatf("run %0d SCORE in done", run_no), exp_score, rd);
            @(posedge prog_clk);
            arrow <= ARROW_RIGHT;
            @(posedge prog_clk);
            arrow <= ARROW_NONE;
            saved_flag  = 1'b1;
            saved_model = exp_score;
            apb_read(ADDR_STATUS, rd);
            check_val($sformatf("run %0d state after right", run_no), ST_MENU, rd[1:0]);
            check_val($sformatf("run %0d saved flag after right", run_no), 32'd1, rd[4]);
            apb_read(ADDR_SAVED, rd);
            check_val($sformatf("run %0d SAVED_SCORE after right", run_no), saved_model, rd);
        end
    endtask

    initial begin
        int n;
        int quit_k;
        void'($urandom(32'hc981_3b80));
        errors      = 0;
        checks      = 0;
        saved_flag  = 1'b0;
        saved_model = '0;
        rst         = 1'b1;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        note_keys   = '0;
        oct_up      = 1'b0;
        oct_down    = 1'b0;
        arrow       = ARROW_NONE;
        repeat (4) @(posedge prog_clk);
        rst <= 1'b0;
        check_reset();
        // Runs 0 and 3 auto play while 5 quits in play and 6 quits in the countdown
        for (int run = 0; run < NUM_RUNS; run++) begin
            n      = 1 + $urandom % CHART_LEN;
            quit_k = -1;
            if (run == 5) begin
                quit_k = COUNT_CYCLES + STEP_CYCLES * ($urandom % n) + 1 + $urandom % STEP_CYCLES;
            end
            if (run == 6) begin
                quit_k = 1 + $urandom % (COUNT_CYCLES - 1);
            end
            play_run(run, (run == 0) || (run == 3), n, quit_k);
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
